/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= tb_controller_standby_i3c
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -xF '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+test
source/i3c_target_pkg.sv
source/bus_monitor.sv
source/i3c_target_fsm.sv
source/flow_standby_i3c.sv
source/tti_queue.sv
source/controller_standby_i3c.sv
test/tb_controller_standby_i3c.sv

/* source/bus_monitor.sv */
// Bus monitor that synchronizes SCL/SDA and flags START, STOP and SCL edges
module bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_det_o,
  output logic stop_det_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic sda_sync_o
);

  // Bits 0 and 1 form the synchronizer, bit 2 keeps the previous value
  logic [2:0] scl_q;
  logic [2:0] sda_q;
  logic       scl_high;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_q <= '1;
      sda_q <= '1;
    end else begin
      scl_q <= {scl_q[1:0], scl_i};
      sda_q <= {sda_q[1:0], sda_i};
    end
  end

  // SCL stable high across the SDA change
  assign scl_high = scl_q[1] & scl_q[2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_det_o <= 1'b0;
      stop_det_o  <= 1'b0;
      scl_rise_o  <= 1'b0;
      scl_fall_o  <= 1'b0;
      sda_sync_o  <= 1'b0;
    end else begin
      start_det_o <= enable_i & scl_high & sda_q[2] & ~sda_q[1];
      stop_det_o  <= enable_i & scl_high & ~sda_q[2] & sda_q[1];
      scl_rise_o  <= enable_i & scl_q[1] & ~scl_q[2];
      scl_fall_o  <= enable_i & ~scl_q[1] & scl_q[2];
      sda_sync_o  <= enable_i & sda_q[1];
    end
  end

endmodule

/* source/controller_standby_i3c.sv */
// I3C secondary controller standby target with TTI RX, descriptor and TX queues
module controller_standby_i3c
  import i3c_target_pkg::*;
#(
  parameter logic [6:0]  StaticAddr = 7'h22,
  parameter int unsigned RxDepth    = 4,
  parameter int unsigned TxDepth    = 4,
  parameter int unsigned DescDepth  = 4
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       target_enable_i,

  // Bus lines, SDA is open drain
  input  logic       scl_i,
  input  logic       sda_i,
  output logic       sda_o,

  output logic       bus_start_o,
  output logic       bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o,

  // TTI RX data
  output logic       rx_rvalid_o,
  input  logic       rx_rready_i,
  output tti_word_t  rx_rdata_o,

  // TTI RX descriptor
  output logic       rx_desc_rvalid_o,
  input  logic       rx_desc_rready_i,
  output rx_desc_t   rx_desc_rdata_o,

  // TTI TX data
  input  logic       tx_wvalid_i,
  output logic       tx_wready_o,
  input  tti_word_t  tx_wdata_i
);

  logic       start_det;
  logic       stop_det;
  logic       scl_rise;
  logic       scl_fall;
  logic       sda_sync;
  logic       rx_byte_valid;
  logic [7:0] rx_byte;
  logic       rx_byte_ready;
  logic       tx_byte_valid;
  logic [7:0] tx_byte;
  logic       tx_byte_ready;
  logic       transfer_start;
  logic       transfer_rnw;
  logic       transfer_end;
  logic       rx_wvalid;
  logic       rx_wready;
  tti_word_t  rx_wdata;
  logic       rx_desc_wvalid;
  logic       rx_desc_wready;
  rx_desc_t   rx_desc_wdata;
  logic       tx_rvalid;
  logic       tx_rready;
  tti_word_t  tx_rdata;

  bus_monitor u_bus_monitor (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .enable_i    (target_enable_i),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .start_det_o (start_det),
    .stop_det_o  (stop_det),
    .scl_rise_o  (scl_rise),
    .scl_fall_o  (scl_fall),
    .sda_sync_o  (sda_sync)
  );

  i3c_target_fsm #(
    .StaticAddr (StaticAddr)
  ) u_target_fsm (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .enable_i         (target_enable_i),
    .start_det_i      (start_det),
    .stop_det_i       (stop_det),
    .scl_rise_i       (scl_rise),
    .scl_fall_i       (scl_fall),
    .sda_i            (sda_sync),
    .sda_o            (sda_o),
    .rx_byte_valid_o  (rx_byte_valid),
    .rx_byte_o        (rx_byte),
    .rx_byte_ready_i  (rx_byte_ready),
    .tx_byte_valid_i  (tx_byte_valid),
    .tx_byte_i        (tx_byte),
    .tx_byte_ready_o  (tx_byte_ready),
    .transfer_start_o (transfer_start),
    .transfer_rnw_o   (transfer_rnw),
    .transfer_end_o   (transfer_end),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o)
  );

  flow_standby_i3c u_flow (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .transfer_start_i (transfer_start),
    .transfer_rnw_i   (transfer_rnw),
    .transfer_end_i   (transfer_end),
    .bus_addr_i       (bus_addr_o[7:1]),
    .rx_byte_valid_i  (rx_byte_valid),
    .rx_byte_i        (rx_byte),
    .rx_byte_ready_o  (rx_byte_ready),
    .tx_byte_valid_o  (tx_byte_valid),
    .tx_byte_o        (tx_byte),
    .tx_byte_ready_i  (tx_byte_ready),
    .rx_wvalid_o      (rx_wvalid),
    .rx_wready_i      (rx_wready),
    .rx_wdata_o       (rx_wdata),
    .rx_desc_wvalid_o (rx_desc_wvalid),
    .rx_desc_wready_i (rx_desc_wready),
    .rx_desc_wdata_o  (rx_desc_wdata),
    .tx_rvalid_i      (tx_rvalid),
    .tx_rready_o      (tx_rready),
    .tx_rdata_i       (tx_rdata)
  );

  tti_queue #(
    .Depth     (RxDepth),
    .payload_t (tti_word_t)
  ) u_rx_queue (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (rx_wvalid),
    .wready_o (rx_wready),
    .wdata_i  (rx_wdata),
    .rvalid_o (rx_rvalid_o),
    .rready_i (rx_rready_i),
    .rdata_o  (rx_rdata_o)
  );

  tti_queue #(
    .Depth     (DescDepth),
    .payload_t (rx_desc_t)
  ) u_rx_desc_queue (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (rx_desc_wvalid),
    .wready_o (rx_desc_wready),
    .wdata_i  (rx_desc_wdata),
    .rvalid_o (rx_desc_rvalid_o),
    .rready_i (rx_desc_rready_i),
    .rdata_o  (rx_desc_rdata_o)
  );

  tti_queue #(
    .Depth     (TxDepth),
    .payload_t (tti_word_t)
  ) u_tx_queue (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (tx_wvalid_i),
    .wready_o (tx_wready_o),
    .wdata_i  (tx_wdata_i),
    .rvalid_o (tx_rvalid),
    .rready_i (tx_rready),
    .rdata_o  (tx_rdata)
  );

  assign bus_start_o = start_det;
  assign bus_stop_o  = stop_det;

endmodule

/* source/flow_standby_i3c.sv */
// TTI flow block packing RX bytes into words and descriptors, unpacking TX words
module flow_standby_i3c
  import i3c_target_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      transfer_start_i,
  input  logic      transfer_rnw_i,
  input  logic      transfer_end_i,
  input  logic [6:0] bus_addr_i,
  input  logic      rx_byte_valid_i,
  input  logic [7:0] rx_byte_i,
  output logic      rx_byte_ready_o,
  output logic      tx_byte_valid_o,
  output logic [7:0] tx_byte_o,
  input  logic      tx_byte_ready_i,
  output logic      rx_wvalid_o,
  input  logic      rx_wready_i,
  output tti_word_t rx_wdata_o,
  output logic      rx_desc_wvalid_o,
  input  logic      rx_desc_wready_i,
  output rx_desc_t  rx_desc_wdata_o,
  input  logic      tx_rvalid_i,
  output logic      tx_rready_o,
  input  tti_word_t tx_rdata_i
);

  logic [1:0]                lane_q;
  logic [ByteCountWidth-1:0] byte_cnt_q;
  logic [6:0]                addr_q;
  logic                      active_q;
  logic                      rnw_q;
  logic                      desc_due_q;
  logic                      tx_have_q;
  tti_word_t                 rx_word_q;
  tti_word_t                 tx_word_q;
  rx_desc_t                  desc_q;
  logic                      rx_accept;
  logic                      tx_accept;
  logic                      tx_pop;
  logic                      desc_issue;

  assign rx_byte_ready_o = rx_wready_i && !rx_wvalid_o && !desc_due_q && !rx_desc_wvalid_o;
  assign rx_accept       = rx_byte_valid_i && rx_byte_ready_o;
  assign tx_accept       = tx_byte_ready_i && tx_have_q;
  assign tx_rready_o     = active_q && rnw_q && !tx_have_q;
  assign tx_pop          = tx_rready_o && tx_rvalid_i;
  // Descriptor goes out only after the last data word has left
  assign desc_issue      = desc_due_q && !rx_wvalid_o;

  assign tx_byte_valid_o = tx_have_q;
  assign tx_byte_o       = tx_word_q[8*lane_q +: 8];
  assign rx_wdata_o      = rx_word_q;
  assign rx_desc_wdata_o = desc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lane_q           <= '0;
      byte_cnt_q       <= '0;
      active_q         <= 1'b0;
      rnw_q            <= 1'b0;
      desc_due_q       <= 1'b0;
      tx_have_q        <= 1'b0;
      rx_wvalid_o      <= 1'b0;
      rx_desc_wvalid_o <= 1'b0;
    end else begin
      if (rx_wvalid_o && rx_wready_i) rx_wvalid_o <= 1'b0;
      if (rx_desc_wvalid_o && rx_desc_wready_i) rx_desc_wvalid_o <= 1'b0;
      if (desc_issue) begin
        rx_desc_wvalid_o <= 1'b1;
        desc_due_q       <= 1'b0;
      end
      if (rx_accept) begin
        lane_q     <= lane_q + 2'd1;
        byte_cnt_q <= byte_cnt_q + 1'b1;
        if (lane_q == 2'd3) rx_wvalid_o <= 1'b1;
      end
      if (tx_pop) begin
        tx_have_q <= 1'b1;
        lane_q    <= '0;
      end
      if (tx_accept) begin
        lane_q <= lane_q + 2'd1;
        if (lane_q == 2'd3) tx_have_q <= 1'b0;
      end
      if (transfer_start_i) begin
        active_q   <= 1'b1;
        rnw_q      <= transfer_rnw_i;
        lane_q     <= '0;
        byte_cnt_q <= '0;
      end
      if (transfer_end_i) begin
        // Unsent read bytes are dropped here
        active_q  <= 1'b0;
        tx_have_q <= 1'b0;
        lane_q    <= '0;
        if (!rnw_q) begin
          desc_due_q <= 1'b1;
          if (lane_q != 2'd0) rx_wvalid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_accept) begin
      if (lane_q == 2'd0) begin
        rx_word_q <= {24'h0, rx_byte_i};
      end else begin
        rx_word_q[8*lane_q +: 8] <= rx_byte_i;
      end
    end
    if (tx_pop) tx_word_q <= tx_rdata_i;
    if (transfer_start_i) addr_q <= bus_addr_i;
    if (desc_issue) begin
      desc_q.rsvd       <= '0;
      desc_q.addr       <= addr_q;
      desc_q.byte_count <= byte_cnt_q;
    end
  end

  a_desc_after_word: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_desc_wvalid_o && rx_desc_wready_i |-> !rx_wvalid_o);

endmodule

/* source/i3c_target_fsm.sv */
// Target FSM for address match, ACK/NACK and SDR private read and write bytes
module i3c_target_fsm
  import i3c_target_pkg::*;
#(
  parameter logic [6:0] StaticAddr = 7'h22
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  logic       start_det_i,
  input  logic       stop_det_i,
  input  logic       scl_rise_i,
  input  logic       scl_fall_i,
  input  logic       sda_i,
  output logic       sda_o,
  output logic       rx_byte_valid_o,
  output logic [7:0] rx_byte_o,
  input  logic       rx_byte_ready_i,
  input  logic       tx_byte_valid_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_byte_ready_o,
  output logic       transfer_start_o,
  output logic       transfer_rnw_o,
  output logic       transfer_end_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o
);

  bus_state_e state_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic [7:0] shift_in;
  logic [7:0] tx_load_byte;
  logic       sda_q;
  logic       ack_half_q;
  logic       ack_ok_q;
  logic       matched_q;
  logic       rnw_q;
  logic       addr_match;
  logic       tx_load;

  assign shift_in     = {shift_q[6:0], sda_i};
  assign addr_match   = enable_i && (shift_in[7:1] == StaticAddr);
  // Nothing queued for this byte, so all ones go out
  assign tx_load_byte = tx_byte_valid_i ? tx_byte_i : 8'hFF;
  assign tx_load      = scl_fall_i && ack_half_q &&
                        ((state_q == StAddrAck && rnw_q) || state_q == StRdAckWait);

  assign sda_o           = sda_q;
  assign tx_byte_ready_o = tx_load;
  assign transfer_rnw_o  = rnw_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q          <= StIdle;
      bit_cnt_q        <= '0;
      shift_q          <= '0;
      sda_q            <= 1'b1;
      ack_half_q       <= 1'b0;
      ack_ok_q         <= 1'b0;
      matched_q        <= 1'b0;
      rnw_q            <= 1'b0;
      rx_byte_valid_o  <= 1'b0;
      rx_byte_o        <= '0;
      transfer_start_o <= 1'b0;
      transfer_end_o   <= 1'b0;
      bus_addr_o       <= '0;
      bus_addr_valid_o <= 1'b0;
    end else begin
      transfer_start_o <= 1'b0;
      transfer_end_o   <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      if (rx_byte_valid_o && rx_byte_ready_i) begin
        rx_byte_valid_o <= 1'b0;
      end
      if (start_det_i || stop_det_i) begin
        // STOP or repeated START closes a matched transfer
        transfer_end_o <= matched_q;
        matched_q      <= 1'b0;
        sda_q          <= 1'b1;
        bit_cnt_q      <= '0;
        state_q        <= start_det_i ? StAddr : StIdle;
      end else begin
        unique case (state_q)
          StIdle: begin
          end
          StAddr: begin
            if (scl_rise_i) begin
              shift_q   <= shift_in;
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                bus_addr_o <= shift_in;
                if (addr_match) begin
                  bus_addr_valid_o <= 1'b1;
                  transfer_start_o <= 1'b1;
                  matched_q        <= 1'b1;
                  rnw_q            <= shift_in[0];
                  ack_half_q       <= 1'b0;
                  state_q          <= StAddrAck;
                end else begin
                  state_q <= StIdle;
                end
              end
            end
          end
          StAddrAck: begin
            if (scl_fall_i) begin
              if (!ack_half_q) begin
                sda_q      <= 1'b0;
                ack_half_q <= 1'b1;
              end else if (rnw_q) begin
                sda_q     <= tx_load_byte[7];
                shift_q   <= {tx_load_byte[6:0], 1'b1};
                bit_cnt_q <= '0;
                state_q   <= StRdData;
              end else begin
                sda_q     <= 1'b1;
                bit_cnt_q <= '0;
                state_q   <= StWrData;
              end
            end
          end
          StWrData: begin
            if (scl_rise_i) begin
              shift_q   <= shift_in;
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                // No room downstream means NACK and drop
                if (rx_byte_ready_i) begin
                  rx_byte_valid_o <= 1'b1;
                  rx_byte_o       <= shift_in;
                end
                ack_ok_q   <= rx_byte_ready_i;
                ack_half_q <= 1'b0;
                state_q    <= StWrAck;
              end
            end
          end
          StWrAck: begin
            if (scl_fall_i) begin
              if (!ack_half_q) begin
                sda_q      <= !ack_ok_q;
                ack_half_q <= 1'b1;
              end else begin
                sda_q     <= 1'b1;
                bit_cnt_q <= '0;
                state_q   <= StWrData;
              end
            end
          end
          StRdData: begin
            if (scl_fall_i) begin
              if (bit_cnt_q == 3'd7) begin
                sda_q      <= 1'b1;
                ack_half_q <= 1'b0;
                state_q    <= StRdAckWait;
              end else begin
                sda_q     <= shift_q[7];
                shift_q   <= {shift_q[6:0], 1'b1};
                bit_cnt_q <= bit_cnt_q + 3'd1;
              end
            end
          end
          StRdAckWait: begin
            if (scl_rise_i) begin
              // Controller NACK ends the read
              if (sda_i) begin
                state_q <= StIdle;
              end else begin
                ack_half_q <= 1'b1;
              end
            end else if (tx_load) begin
              sda_q     <= tx_load_byte[7];
              shift_q   <= {tx_load_byte[6:0], 1'b1};
              bit_cnt_q <= '0;
              state_q   <= StRdData;
            end
          end
          default: state_q <= StIdle;
        endcase
      end
    end
  end

  // Target pulls SDA only for an ACK or a read data bit
  a_sda_low_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !sda_o |-> state_q inside {StAddrAck, StWrAck, StRdData});

  a_rx_byte_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_byte_valid_o && !rx_byte_ready_i |=> rx_byte_valid_o && $stable(rx_byte_o));

endmodule

/* source/i3c_target_pkg.sv */
// I3C standby target package with TTI payload types and target FSM states
package i3c_target_pkg;

  // Width of the byte count field in an RX descriptor
  localparam int unsigned ByteCountWidth = 16;

  // One TTI data word, bytes packed least significant first
  typedef logic [31:0] tti_word_t;

  // One RX descriptor per private write, padded to 32 bits
  typedef struct packed {
    logic [8:0]                rsvd;
    logic [6:0]                addr;
    logic [ByteCountWidth-1:0] byte_count;
  } rx_desc_t;

  typedef enum logic [2:0] {
    StIdle,
    StAddr,
    StAddrAck,
    StWrData,
    StWrAck,
    StRdData,
    StRdAckWait
  } bus_state_e;

endpackage

/* source/tti_queue.sv */
// TTI queue, a synchronous FIFO with valid/ready on both sides
module tti_queue
  import i3c_target_pkg::*;
#(
  parameter int unsigned Depth = 4,
  parameter type payload_t = tti_word_t
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  input  payload_t wdata_i,
  output logic     rvalid_o,
  input  logic     rready_i,
  output payload_t rdata_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   wptr_q;
  logic [PtrWidth-1:0]   rptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  push;
  logic                  pop;

  assign wready_o = (count_q != CntWidth'(Depth));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrWidth'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrWidth'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q] <= wdata_i;
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntWidth'(Depth));

endmodule

/* test/i3c_bus_tasks.svh */
// I3C bus controller model that drives SCL and an open-drain SDA line
`ifndef I3C_BUS_TASKS_SVH
`define I3C_BUS_TASKS_SVH

// Advance n clocks and land on the drive point after the edge
task automatic step_clk(input int n);
  repeat (n) @(posedge clk_i);
  #(DriveDelay);
endtask

// One SCL period, entered and left with SCL low
task automatic clock_bit(input logic bit_val, output logic seen);
  step_clk(HalfPeriod / 2);
  sda_drv = bit_val;
  step_clk(HalfPeriod - HalfPeriod / 2);
  scl_i = 1'b1;
  // Sample late in the high phase
  step_clk(HalfPeriod - 1);
  seen = sda_i;
  step_clk(1);
  scl_i = 1'b0;
endtask

// Also serves as a repeated START when SCL is low
task automatic bus_start();
  step_clk(2);
  sda_drv = 1'b1;
  step_clk(2);
  scl_i = 1'b1;
  step_clk(HalfPeriod);
  sda_drv = 1'b0;
  step_clk(HalfPeriod);
  scl_i = 1'b0;
endtask

task automatic bus_stop();
  step_clk(2);
  sda_drv = 1'b0;
  step_clk(2);
  scl_i = 1'b1;
  step_clk(HalfPeriod);
  sda_drv = 1'b1;
  step_clk(HalfPeriod);
endtask

// Eight bits MSB first, then the ACK slot with SDA released
task automatic write_byte(input logic [7:0] data, output logic acked);
  logic seen;
  int   i;
  for (i = 7; i >= 0; i--) begin
    clock_bit(data[i], seen);
  end
  clock_bit(1'b1, seen);
  acked = !seen;
endtask

task automatic read_byte(input logic ack, output logic [7:0] data);
  logic seen;
  int   i;
  data = '0;
  for (i = 7; i >= 0; i--) begin
    clock_bit(1'b1, seen);
    data[i] = seen;
  end
  // Low is ACK, high is NACK
  clock_bit(!ack, seen);
endtask

`endif

/* test/tb_controller_standby_i3c.sv */
// Testbench for the I3C standby target with a bus controller model and TTI queue checks
module tb_controller_standby_i3c;

  localparam logic [6:0] TargetAddr = 7'h22;
  localparam logic [6:0] OtherAddr  = 7'h35;
  localparam int         RxDepth    = 4;
  localparam int         HalfPeriod = 4;
  localparam int         DriveDelay = 10;
  localparam int         DrainLimit = 400;
  localparam int         ReadyLimit = 100;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        target_enable_i;
  logic        scl_i;
  logic        sda_drv;
  wire         sda_i;
  logic        sda_o;
  logic        bus_start_o;
  logic        bus_stop_o;
  logic [7:0]  bus_addr_o;
  logic        bus_addr_valid_o;
  logic        rx_rvalid_o;
  logic        rx_rready_i;
  logic [31:0] rx_rdata_o;
  logic        rx_desc_rvalid_o;
  logic        rx_desc_rready_i;
  logic [31:0] rx_desc_rdata_o;
  logic        tx_wvalid_i;
  logic        tx_wready_o;
  logic [31:0] tx_wdata_i;

  logic [7:0]  wr_data [32];
  logic        wr_ack [32];
  logic [7:0]  rd_data [32];
  logic [31:0] tx_words [8];
  logic [31:0] exp_words [$];
  logic [31:0] exp_descs [$];
  logic [31:0] cmp_word;
  logic [31:0] cmp_desc;

  int seed;
  int err_cnt = 0;
  int cmp_err_cnt = 0;
  int test_cnt = 0;
  int failed_tests = 0;
  int errs_at_start;
  int start_cnt = 0;
  int stop_cnt = 0;
  int addr_valid_cnt = 0;
  int word_cnt = 0;
  int desc_cnt = 0;
  int start_base;
  int stop_base;
  int addr_valid_base;
  int word_base;
  int desc_base;

  // Wired-AND of the controller model and the target
  assign sda_i = sda_drv & sda_o;

  always #50 clk_i = ~clk_i;

  controller_standby_i3c #(
    .StaticAddr (TargetAddr),
    .RxDepth    (RxDepth),
    .TxDepth    (4),
    .DescDepth  (4)
  ) u_dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .target_enable_i  (target_enable_i),
    .scl_i            (scl_i),
    .sda_i            (sda_i),
    .sda_o            (sda_o),
    .bus_start_o      (bus_start_o),
    .bus_stop_o       (bus_stop_o),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o),
    .rx_rvalid_o      (rx_rvalid_o),
    .rx_rready_i      (rx_rready_i),
    .rx_rdata_o       (rx_rdata_o),
    .rx_desc_rvalid_o (rx_desc_rvalid_o),
    .rx_desc_rready_i (rx_desc_rready_i),
    .rx_desc_rdata_o  (rx_desc_rdata_o),
    .tx_wvalid_i      (tx_wvalid_i),
    .tx_wready_o      (tx_wready_o),
    .tx_wdata_i       (tx_wdata_i)
  );

  `include "i3c_bus_tasks.svh"

  // Word w of a byte list packed LSB first and zero past the last byte
  function automatic logic [31:0] pack_word(input logic [7:0] data [32], input int n,
                                            input int w);
    logic [31:0] word;
    int          k;
    word = '0;
    for (k = 0; k < 4; k++) begin
      if (4 * w + k < n) word[8*k +: 8] = data[4*w + k];
    end
    return word;
  endfunction

  // Count in bits 15:0 and address in bits 22:16
  function automatic logic [31:0] make_desc(input int count, input logic [6:0] addr);
    return {9'h0, addr, count[15:0]};
  endfunction

  function automatic logic [7:0] unpack_byte(input logic [31:0] words [8], input int idx);
    return words[idx / 4][8 * (idx % 4) +: 8];
  endfunction

  always @(negedge clk_i) begin
    if (bus_start_o) start_cnt++;
    if (bus_stop_o) stop_cnt++;
    if (bus_addr_valid_o) addr_valid_cnt++;
  end

  // Transfers happen on the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i && rx_rvalid_o && rx_rready_i) begin
      word_cnt++;
      if (exp_words.size() == 0) begin
        $display("Unexpected RX word %h at time %0t", rx_rdata_o, $time);
        cmp_err_cnt++;
      end else begin
        cmp_word = exp_words.pop_front();
        if (rx_rdata_o !== cmp_word) begin
          $display("ERR t=%0t rx_rdata_o exp=%h got=%h", $time, cmp_word, rx_rdata_o);
          cmp_err_cnt++;
        end
      end
    end
    if (rst_n_i && rx_desc_rvalid_o && rx_desc_rready_i) begin
      desc_cnt++;
      if (exp_descs.size() == 0) begin
        $display("Unexpected RX descriptor %h at time %0t", rx_desc_rdata_o, $time);
        cmp_err_cnt++;
      end else begin
        cmp_desc = exp_descs.pop_front();
        if (rx_desc_rdata_o !== cmp_desc) begin
          $display("ERR t=%0t rx_desc_rdata_o exp=%h got=%h", $time, cmp_desc,
                   rx_desc_rdata_o);
          cmp_err_cnt++;
        end
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic begin_test();
    errs_at_start   = err_cnt + cmp_err_cnt;
    start_base      = start_cnt;
    stop_base       = stop_cnt;
    addr_valid_base = addr_valid_cnt;
    word_base       = word_cnt;
    desc_base       = desc_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt + cmp_err_cnt == errs_at_start) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_cnt, name,
               err_cnt + cmp_err_cnt - errs_at_start);
    end
  endtask

  task automatic check_events(input int starts, input int stops, input int addr_valids);
    if (start_cnt - start_base != starts) begin
      report_mismatch("bus_start_o pulses", starts, start_cnt - start_base);
    end
    if (stop_cnt - stop_base != stops) begin
      report_mismatch("bus_stop_o pulses", stops, stop_cnt - stop_base);
    end
    if (addr_valid_cnt - addr_valid_base != addr_valids) begin
      report_mismatch("bus_addr_valid_o pulses", addr_valids,
                      addr_valid_cnt - addr_valid_base);
    end
  endtask

  task automatic check_no_rx();
    if (word_cnt != word_base) report_mismatch("rx_rdata_o words", 0, word_cnt - word_base);
    if (desc_cnt != desc_base) report_mismatch("rx_desc_rdata_o descs", 0, desc_cnt - desc_base);
    if (rx_rvalid_o !== 1'b0) report_mismatch("rx_rvalid_o", 0, rx_rvalid_o);
    if (rx_desc_rvalid_o !== 1'b0) report_mismatch("rx_desc_rvalid_o", 0, rx_desc_rvalid_o);
  endtask

  task automatic expect_write(input int n, input logic [6:0] addr);
    int w;
    for (w = 0; w < (n + 3) / 4; w++) begin
      exp_words.push_back(pack_word(wr_data, n, w));
    end
    exp_descs.push_back(make_desc(n, addr));
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_words.size() != 0 || exp_descs.size() != 0) && n < DrainLimit) begin
      step_clk(1);
      n++;
    end
    if (exp_words.size() != 0 || exp_descs.size() != 0) begin
      $display("Timeout at %0t with %0d RX words and %0d descriptors still missing",
               $time, exp_words.size(), exp_descs.size());
      err_cnt++;
    end
  endtask

  task automatic push_tx(input logic [31:0] word);
    int n;
    tx_wvalid_i = 1'b1;
    tx_wdata_i  = word;
    n = 0;
    while (!tx_wready_o && n < ReadyLimit) begin
      step_clk(1);
      n++;
    end
    if (!tx_wready_o) begin
      $display("TX queue never became ready, timeout at %0t", $time);
      err_cnt++;
    end
    step_clk(1);
    tx_wvalid_i = 1'b0;
  endtask

  task automatic private_write(input logic [6:0] addr, input int n, output logic addr_ack);
    int i;
    bus_start();
    write_byte({addr, 1'b0}, addr_ack);
    for (i = 0; i < n; i++) begin
      write_byte(wr_data[i], wr_ack[i]);
    end
    bus_stop();
  endtask

  // Last byte is NACKed to end the read
  task automatic private_read(input logic [6:0] addr, input int n, output logic addr_ack);
    int i;
    bus_start();
    write_byte({addr, 1'b1}, addr_ack);
    for (i = 0; i < n; i++) begin
      read_byte(i != n - 1, rd_data[i]);
    end
    bus_stop();
  endtask

  initial begin
    int   i;
    logic addr_ack;
    seed             = 1;
    rst_n_i          = 1'b0;
    target_enable_i  = 1'b1;
    scl_i            = 1'b1;
    sda_drv          = 1'b1;
    rx_rready_i      = 1'b1;
    rx_desc_rready_i = 1'b1;
    tx_wvalid_i      = 1'b0;
    tx_wdata_i       = '0;
    repeat (4) @(posedge clk_i);
    #(DriveDelay);
    rst_n_i = 1'b1;
    step_clk(2);

    begin_test();
    if (sda_o !== 1'b1) report_mismatch("sda_o", 1, sda_o);
    if (rx_rvalid_o !== 1'b0) report_mismatch("rx_rvalid_o", 0, rx_rvalid_o);
    if (rx_desc_rvalid_o !== 1'b0) report_mismatch("rx_desc_rvalid_o", 0, rx_desc_rvalid_o);
    if (bus_addr_valid_o !== 1'b0) report_mismatch("bus_addr_valid_o", 0, bus_addr_valid_o);
    if (tx_wready_o !== 1'b1) report_mismatch("tx_wready_o", 1, tx_wready_o);
    end_test("reset values");

    begin_test();
    for (i = 0; i < 6; i++) wr_data[i] = 8'($random(seed));
    expect_write(6, TargetAddr);
    private_write(TargetAddr, 6, addr_ack);
    if (addr_ack !== 1'b1) report_mismatch("sda_o (address ACK)", 1, addr_ack);
    for (i = 0; i < 6; i++) begin
      if (wr_ack[i] !== 1'b1) report_mismatch($sformatf("sda_o (ACK of byte %0d)", i), 1,
                                              wr_ack[i]);
    end
    wait_drained();
    check_events(1, 1, 1);
    if (bus_addr_o !== {TargetAddr, 1'b0}) report_mismatch("bus_addr_o",
                                                          {TargetAddr, 1'b0}, bus_addr_o);
    end_test("private write");

    begin_test();
    private_write(OtherAddr, 0, addr_ack);
    step_clk(20);
    if (addr_ack !== 1'b0) report_mismatch("sda_o (address ACK)", 0, addr_ack);
    check_events(1, 1, 0);
    check_no_rx();
    end_test("other address");

    begin_test();
    for (i = 0; i < 2; i++) begin
      tx_words[i] = $random(seed);
      push_tx(tx_words[i]);
    end
    private_read(TargetAddr, 8, addr_ack);
    if (addr_ack !== 1'b1) report_mismatch("sda_o (address ACK)", 1, addr_ack);
    for (i = 0; i < 8; i++) begin
      if (rd_data[i] !== unpack_byte(tx_words, i)) begin
        report_mismatch($sformatf("sda_o (read byte %0d)", i), unpack_byte(tx_words, i),
                        rd_data[i]);
      end
    end
    check_events(1, 1, 1);
    end_test("private read");

    // RX queue held full so the tail of the write is refused
    begin_test();
    rx_rready_i = 1'b0;
    for (i = 0; i < 20; i++) wr_data[i] = 8'($random(seed));
    expect_write(16, TargetAddr);
    private_write(TargetAddr, 20, addr_ack);
    if (addr_ack !== 1'b1) report_mismatch("sda_o (address ACK)", 1, addr_ack);
    for (i = 0; i < 20; i++) begin
      if (wr_ack[i] !== (i < 16)) report_mismatch($sformatf("sda_o (ACK of byte %0d)", i),
                                                  (i < 16), wr_ack[i]);
    end
    step_clk(4);
    if (rx_rvalid_o !== 1'b1) report_mismatch("rx_rvalid_o", 1, rx_rvalid_o);
    rx_rready_i = 1'b1;
    wait_drained();
    if (word_cnt - word_base != 4) report_mismatch("rx_rdata_o words", 4, word_cnt - word_base);
    end_test("back-pressure");

    begin_test();
    target_enable_i = 1'b0;
    step_clk(4);
    private_write(TargetAddr, 0, addr_ack);
    step_clk(20);
    if (addr_ack !== 1'b0) report_mismatch("sda_o (address ACK)", 0, addr_ack);
    check_events(0, 0, 0);
    check_no_rx();
    target_enable_i = 1'b1;
    step_clk(4);
    end_test("disabled target");

    $display("tests %0d, failed tests %0d, errors %0d", test_cnt, failed_tests,
             err_cnt + cmp_err_cnt);
    if (failed_tests == 0 && err_cnt + cmp_err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
